// File: design/csr_pkg.sv
// Shared types, CSR addresses, write masks and constants for the machine-mode CSR bank
// Compiled first; modules import it inside their bodies

package csr_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    typedef logic [31:0] xlen_t;        // One data word
    typedef logic [11:0] csr_addr_t;
    typedef logic [4:0]  exc_code_t;    // Exception cause code
    typedef logic [4:0]  irq_code_t;    // Interrupt cause code

    // Standard RISC-V machine and user CSR addresses
    typedef enum csr_addr_t {
        MSTATUS   = 12'h300,
        MISA      = 12'h301,
        MIE       = 12'h304,
        MTVEC     = 12'h305,
        MSCRATCH  = 12'h340,
        MEPC      = 12'h341,
        MCAUSE    = 12'h342,
        MTVAL     = 12'h343,
        MIP       = 12'h344,
        MCYCLE    = 12'hB00,
        MINSTRET  = 12'hB02,
        MCYCLEH   = 12'hB80,
        MINSTRETH = 12'hB82,
        CYCLE     = 12'hC00,
        INSTRET   = 12'hC02,
        CYCLEH    = 12'hC80,
        INSTRETH  = 12'hC82
    } csr_addr_e;

    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    localparam exc_code_t EXC_ILLEGAL_INSTR = 5'd2;

    localparam irq_code_t IRQ_M_SW  = 5'd3;
    localparam irq_code_t IRQ_M_TIM = 5'd7;
    localparam irq_code_t IRQ_M_EXT = 5'd11;

    //////////////////////////////
    // Write masks
    //////////////////////////////

    localparam xlen_t MASK_MSTATUS = 32'h0000_1888;    // MPP, MPIE, MIE
    localparam xlen_t MASK_MIE     = 32'h0000_0888;    // MEIE, MTIE, MSIE
    localparam xlen_t MASK_MTVEC   = 32'hFFFF_FFFC;    // Direct mode, word aligned
    localparam xlen_t MASK_MEPC    = 32'hFFFF_FFFC;
    localparam xlen_t MASK_FULL    = 32'hFFFF_FFFF;

    // MXL = 1 (RV32), U and I extension bits
    localparam xlen_t MISA_VALUE = 32'h4010_0100;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    //////////////////////////////
    // Write strobes
    //////////////////////////////

    localparam int WS_COUNT = 11;
    typedef logic [WS_COUNT-1:0] csr_wsel_t;  // One-hot

    localparam int WS_MSTATUS   = 0;
    localparam int WS_MIE       = 1;
    localparam int WS_MTVEC     = 2;
    localparam int WS_MSCRATCH  = 3;
    localparam int WS_MEPC      = 4;
    localparam int WS_MCAUSE    = 5;
    localparam int WS_MTVAL     = 6;
    localparam int WS_MCYCLE    = 7;
    localparam int WS_MCYCLEH   = 8;
    localparam int WS_MINSTRET  = 9;
    localparam int WS_MINSTRETH = 10;

endpackage

// File: design/csr_access.sv
// Write side of the CSR bank: address decode, mask selection, set/clear merge
// Produces the masked write data and one-hot write strobes for the register blocks

`timescale 1ns/1ps

module csr_access (
    input  logic                write_en_i,
    input  logic                killed_i,
    input  csr_pkg::csr_op_e    op_i,
    input  csr_pkg::csr_addr_t  addr_i,
    input  csr_pkg::xlen_t      wdata_i,
    input  csr_pkg::xlen_t      cur_val_i,    // Unmasked value of addressed register
    output csr_pkg::xlen_t      wr_data_o,
    output csr_pkg::csr_wsel_t  wsel_o
);

    import csr_pkg::*;

    xlen_t     wmask;
    xlen_t     merged;
    csr_wsel_t sel;
    logic      write_allowed;

    assign write_allowed = write_en_i && !killed_i;

    //////////////////////////////
    // Mask and strobe decode
    //////////////////////////////

    always_comb begin
        wmask = '0;     // Read-only and unmapped
        sel   = '0;
        case (addr_i)
            MSTATUS:   begin wmask = MASK_MSTATUS; sel[WS_MSTATUS]   = 1'b1; end
            MIE:       begin wmask = MASK_MIE;     sel[WS_MIE]       = 1'b1; end
            MTVEC:     begin wmask = MASK_MTVEC;   sel[WS_MTVEC]     = 1'b1; end
            MSCRATCH:  begin wmask = MASK_FULL;    sel[WS_MSCRATCH]  = 1'b1; end
            MEPC:      begin wmask = MASK_MEPC;    sel[WS_MEPC]      = 1'b1; end
            MCAUSE:    begin wmask = MASK_FULL;    sel[WS_MCAUSE]    = 1'b1; end
            MTVAL:     begin wmask = MASK_FULL;    sel[WS_MTVAL]     = 1'b1; end
            MCYCLE:    begin wmask = MASK_FULL;    sel[WS_MCYCLE]    = 1'b1; end
            MCYCLEH:   begin wmask = MASK_FULL;    sel[WS_MCYCLEH]   = 1'b1; end
            MINSTRET:  begin wmask = MASK_FULL;    sel[WS_MINSTRET]  = 1'b1; end
            MINSTRETH: begin wmask = MASK_FULL;    sel[WS_MINSTRETH] = 1'b1; end
            default: ;
        endcase
    end

    //////////////////////////////
    // Operation merge
    //////////////////////////////

    always_comb begin
        case (op_i)
            CSR_SET:   merged = cur_val_i | wdata_i;
            CSR_CLEAR: merged = cur_val_i & ~wdata_i;
            default:   merged = wdata_i;            // Plain write
        endcase
    end

    assign wr_data_o = merged & wmask;
    assign wsel_o    = write_allowed ? sel : '0;

endmodule

// File: design/csr_trap_regs.sv
// Trap state registers and privilege level of the CSR bank
// Handles machine return, exception entry, interrupt entry and plain CSR writes

`timescale 1ns/1ps

module csr_trap_regs (
    input  logic                clk,
    input  logic                reset_n,
    input  csr_pkg::xlen_t      wr_data_i,
    input  csr_pkg::csr_wsel_t  wsel_i,
    input  logic                raise_exception_i,
    input  logic                machine_return_i,
    input  logic                interrupt_ack_i,
    input  logic                jump_i,
    input  csr_pkg::exc_code_t  exception_code_i,
    input  csr_pkg::irq_code_t  irq_cause_i,
    input  csr_pkg::xlen_t      pc_i,
    input  csr_pkg::xlen_t      instruction_i,
    input  csr_pkg::xlen_t      jump_target_i,
    output csr_pkg::xlen_t      mstatus_o,
    output csr_pkg::xlen_t      mie_o,
    output csr_pkg::xlen_t      mtvec_o,
    output csr_pkg::xlen_t      mscratch_o,
    output csr_pkg::xlen_t      mepc_o,
    output csr_pkg::xlen_t      mcause_o,
    output csr_pkg::xlen_t      mtval_o,
    output csr_pkg::priv_e      privilege_o
);

    import csr_pkg::*;

    // Implemented mstatus fields
    logic  st_mie;
    logic  st_mpie;
    priv_e st_mpp;

    always_comb begin
        mstatus_o                          = '0;
        mstatus_o[MSTATUS_MIE_BIT]         = st_mie;
        mstatus_o[MSTATUS_MPIE_BIT]        = st_mpie;
        mstatus_o[MSTATUS_MPP_LSB +: 2]    = st_mpp;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            st_mie      <= 1'b0;
            st_mpie     <= 1'b0;
            st_mpp      <= PRIV_USER;
            mie_o       <= '0;
            mtvec_o     <= '0;
            mscratch_o  <= '0;
            mepc_o      <= '0;
            mcause_o    <= '0;
            mtval_o     <= '0;
            privilege_o <= PRIV_MACHINE;
        end else if (machine_return_i) begin
            st_mie      <= st_mpie;
            privilege_o <= st_mpp;
        end else if (raise_exception_i) begin
            mcause_o    <= {1'b0, 26'd0, exception_code_i};
            mepc_o      <= pc_i;
            mtval_o     <= (exception_code_i == EXC_ILLEGAL_INSTR) ? instruction_i : pc_i;
            st_mpie     <= st_mie;
            st_mie      <= 1'b0;
            st_mpp      <= privilege_o;
            privilege_o <= PRIV_MACHINE;
        end else if (interrupt_ack_i) begin
            mcause_o    <= {1'b1, 26'd0, irq_cause_i};
            mepc_o      <= jump_i ? jump_target_i : pc_i;   // Resume at branch target
            st_mpie     <= st_mie;
            st_mie      <= 1'b0;
            st_mpp      <= privilege_o;
            privilege_o <= PRIV_MACHINE;
        end else begin
            //////////////////////////////
            // CSR writes
            //////////////////////////////
            if (wsel_i[WS_MSTATUS]) begin
                st_mie  <= wr_data_i[MSTATUS_MIE_BIT];
                st_mpie <= wr_data_i[MSTATUS_MPIE_BIT];
                st_mpp  <= priv_e'(wr_data_i[MSTATUS_MPP_LSB +: 2]);
            end
            if (wsel_i[WS_MIE]) begin
                mie_o <= wr_data_i;
            end
            if (wsel_i[WS_MTVEC]) begin
                mtvec_o <= wr_data_i;
            end
            if (wsel_i[WS_MSCRATCH]) begin
                mscratch_o <= wr_data_i;
            end
            if (wsel_i[WS_MEPC]) begin
                mepc_o <= wr_data_i;
            end
            if (wsel_i[WS_MCAUSE]) begin
                mcause_o <= wr_data_i;
            end
            if (wsel_i[WS_MTVAL]) begin
                mtval_o <= wr_data_i;
            end
        end
    end

endmodule

// File: design/csr_counters.sv
// 64-bit cycle and retired-instruction counters
// Either half can be overwritten through the CSR write strobes

`timescale 1ns/1ps

module csr_counters (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                killed_i,
    input  csr_pkg::xlen_t      wr_data_i,
    input  csr_pkg::csr_wsel_t  wsel_i,
    output logic [63:0]         mcycle_o,
    output logic [63:0]         minstret_o
);

    import csr_pkg::*;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle_o <= '0;
        end else if (wsel_i[WS_MCYCLE]) begin
            mcycle_o <= {mcycle_o[63:32], wr_data_i};
        end else if (wsel_i[WS_MCYCLEH]) begin
            mcycle_o <= {wr_data_i, mcycle_o[31:0]};
        end else begin
            mcycle_o <= mcycle_o + 64'd1;   // Free running
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            minstret_o <= '0;
        end else if (wsel_i[WS_MINSTRET]) begin
            minstret_o <= {minstret_o[63:32], wr_data_i};
        end else if (wsel_i[WS_MINSTRETH]) begin
            minstret_o <= {wr_data_i, minstret_o[31:0]};
        end else if (!killed_i) begin
            minstret_o <= minstret_o + 64'd1;   // Retired instruction
        end
    end

endmodule

// File: design/csr_irq_ctrl.sv
// Interrupt sampling and prioritisation for the CSR bank
// Registers mip, the pending flag and the winning cause code

`timescale 1ns/1ps

module csr_irq_ctrl (
    input  logic                clk,
    input  logic                reset_n,
    input  csr_pkg::xlen_t      irq_i,
    input  logic                mstatus_mie_i,
    input  logic                interrupt_ack_i,
    input  csr_pkg::xlen_t      mie_i,
    output csr_pkg::xlen_t      mip_o,
    output logic                interrupt_pending_o,
    output csr_pkg::irq_code_t  irq_cause_o
);

    import csr_pkg::*;

    xlen_t     enabled;
    irq_code_t cause_next;
    logic      take;

    assign enabled = mie_i & mip_o;
    assign take    = mstatus_mie_i && (enabled != '0) && !interrupt_ack_i;

    // External first, then software, then timer
    always_comb begin
        cause_next = irq_cause_o;
        if (enabled[IRQ_M_EXT]) begin
            cause_next = IRQ_M_EXT;
        end else if (enabled[IRQ_M_SW]) begin
            cause_next = IRQ_M_SW;
        end else if (enabled[IRQ_M_TIM]) begin
            cause_next = IRQ_M_TIM;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mip_o               <= '0;
            interrupt_pending_o <= 1'b0;
            irq_cause_o         <= '0;
        end else begin
            mip_o               <= irq_i;   // Sampled every edge
            interrupt_pending_o <= take;
            if (take) begin
                irq_cause_o <= cause_next;
            end
        end
    end

endmodule

// File: design/csr_read_mux.sv
// Read side of the CSR bank: selects the addressed register value
// The raw value feeds the write merge; the gated value is the core's read data

`timescale 1ns/1ps

module csr_read_mux (
    input  logic                read_en_i,
    input  logic                killed_i,
    input  csr_pkg::csr_addr_t  addr_i,
    input  csr_pkg::xlen_t      mstatus_i,
    input  csr_pkg::xlen_t      mie_i,
    input  csr_pkg::xlen_t      mtvec_i,
    input  csr_pkg::xlen_t      mscratch_i,
    input  csr_pkg::xlen_t      mepc_i,
    input  csr_pkg::xlen_t      mcause_i,
    input  csr_pkg::xlen_t      mtval_i,
    input  csr_pkg::xlen_t      mip_i,
    input  logic [63:0]         mcycle_i,
    input  logic [63:0]         minstret_i,
    output csr_pkg::xlen_t      cur_val_o,
    output csr_pkg::xlen_t      rdata_o
);

    import csr_pkg::*;

    logic read_allowed;

    assign read_allowed = read_en_i && !killed_i;

    always_comb begin
        case (addr_i)
            MSTATUS:   cur_val_o = mstatus_i;
            MISA:      cur_val_o = MISA_VALUE;     // Fixed, writes ignored
            MIE:       cur_val_o = mie_i;
            MTVEC:     cur_val_o = mtvec_i;
            MSCRATCH:  cur_val_o = mscratch_i;
            MEPC:      cur_val_o = mepc_i;
            MCAUSE:    cur_val_o = mcause_i;
            MTVAL:     cur_val_o = mtval_i;
            MIP:       cur_val_o = mip_i;
            MCYCLE:    cur_val_o = mcycle_i[31:0];
            MCYCLEH:   cur_val_o = mcycle_i[63:32];
            MINSTRET:  cur_val_o = minstret_i[31:0];
            MINSTRETH: cur_val_o = minstret_i[63:32];
            // User counters alias the machine ones
            CYCLE:     cur_val_o = mcycle_i[31:0];
            CYCLEH:    cur_val_o = mcycle_i[63:32];
            INSTRET:   cur_val_o = minstret_i[31:0];
            INSTRETH:  cur_val_o = minstret_i[63:32];
            default:   cur_val_o = '0;             // Unmapped
        endcase
    end

    assign rdata_o = read_allowed ? cur_val_o : '0;

endmodule

// File: design/csr_bank.sv
// Machine-mode CSR bank of the RV32 core, accessed in one cycle by the pipeline
// Connects the write decode, trap registers, counters, interrupt logic and read mux

`timescale 1ns/1ps

module csr_bank (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                read_en_i,
    input  logic                write_en_i,
    input  logic                killed_i,
    input  csr_pkg::csr_op_e    op_i,
    input  csr_pkg::csr_addr_t  addr_i,
    input  csr_pkg::xlen_t      wdata_i,
    output csr_pkg::xlen_t      rdata_o,
    input  logic                raise_exception_i,
    input  csr_pkg::exc_code_t  exception_code_i,
    input  logic                machine_return_i,
    input  logic                interrupt_ack_i,
    input  csr_pkg::xlen_t      pc_i,
    input  csr_pkg::xlen_t      instruction_i,
    input  logic                jump_i,
    input  csr_pkg::xlen_t      jump_target_i,
    input  csr_pkg::xlen_t      irq_i,
    output logic                interrupt_pending_o,
    output csr_pkg::priv_e      privilege_o,
    output csr_pkg::xlen_t      mepc_o,
    output csr_pkg::xlen_t      mtvec_o
);

    import csr_pkg::*;

    xlen_t       cur_val;
    xlen_t       wr_data;
    csr_wsel_t   wsel;
    xlen_t       mstatus, mie, mscratch, mcause, mtval, mip;
    irq_code_t   irq_cause;
    logic [63:0] mcycle, minstret;

    csr_access u_access (
        .write_en_i (write_en_i),
        .killed_i   (killed_i),
        .op_i       (op_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .cur_val_i  (cur_val),
        .wr_data_o  (wr_data),
        .wsel_o     (wsel)
    );

    csr_trap_regs u_trap_regs (
        .clk               (clk),
        .reset_n           (reset_n),
        .wr_data_i         (wr_data),
        .wsel_i            (wsel),
        .raise_exception_i (raise_exception_i),
        .machine_return_i  (machine_return_i),
        .interrupt_ack_i   (interrupt_ack_i),
        .jump_i            (jump_i),
        .exception_code_i  (exception_code_i),
        .irq_cause_i       (irq_cause),
        .pc_i              (pc_i),
        .instruction_i     (instruction_i),
        .jump_target_i     (jump_target_i),
        .mstatus_o         (mstatus),
        .mie_o             (mie),
        .mtvec_o           (mtvec_o),
        .mscratch_o        (mscratch),
        .mepc_o            (mepc_o),
        .mcause_o          (mcause),
        .mtval_o           (mtval),
        .privilege_o       (privilege_o)
    );

    csr_counters u_counters (
        .clk        (clk),
        .reset_n    (reset_n),
        .killed_i   (killed_i),
        .wr_data_i  (wr_data),
        .wsel_i     (wsel),
        .mcycle_o   (mcycle),
        .minstret_o (minstret)
    );

    csr_irq_ctrl u_irq_ctrl (
        .clk                 (clk),
        .reset_n             (reset_n),
        .irq_i               (irq_i),
        .mstatus_mie_i       (mstatus[MSTATUS_MIE_BIT]),
        .interrupt_ack_i     (interrupt_ack_i),
        .mie_i               (mie),
        .mip_o               (mip),
        .interrupt_pending_o (interrupt_pending_o),
        .irq_cause_o         (irq_cause)
    );

    csr_read_mux u_read_mux (
        .read_en_i  (read_en_i),
        .killed_i   (killed_i),
        .addr_i     (addr_i),
        .mstatus_i  (mstatus),
        .mie_i      (mie),
        .mtvec_i    (mtvec_o),
        .mscratch_i (mscratch),
        .mepc_i     (mepc_o),
        .mcause_i   (mcause),
        .mtval_i    (mtval),
        .mip_i      (mip),
        .mcycle_i   (mcycle),
        .minstret_i (minstret),
        .cur_val_o  (cur_val),
        .rdata_o    (rdata_o)
    );

endmodule

// File: sim/csr_tb_tasks.svh
// Access tasks, reference merge and mask rules, and the LCG of the CSR bank testbench
// Included inside the testbench module after the mirror and check helpers

`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

xlen_t lcg_state = 32'h95cd;

function automatic xlen_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Writable bits per address, zero for read-only and unmapped
function automatic xlen_t ref_mask(input csr_addr_t addr);
    case (addr)
        MSTATUS:         return 32'h0000_1888;     // MIE, MPIE, MPP
        MIE:             return 32'h0000_0888;
        MTVEC, MEPC:     return 32'hFFFF_FFFC;     // Word aligned
        MSCRATCH, MCAUSE, MTVAL, MCYCLE, MCYCLEH, MINSTRET, MINSTRETH: return 32'hFFFF_FFFF;
        default:         return 32'h0;
    endcase
endfunction

function automatic xlen_t ref_merge(input csr_op_e op, input xlen_t old, input xlen_t operand);
    case (op)
        CSR_SET:   return old | operand;
        CSR_CLEAR: return old & ~operand;
        default:   return operand;
    endcase
endfunction

// Everything quiet except reset and the interrupt lines
task automatic idle_inputs();
    read_en_i         = 1'b0;
    write_en_i        = 1'b0;
    killed_i          = 1'b0;
    op_i              = CSR_WRITE;
    addr_i            = '0;
    wdata_i           = '0;
    raise_exception_i = 1'b0;
    exception_code_i  = '0;
    machine_return_i  = 1'b0;
    interrupt_ack_i   = 1'b0;
    pc_i              = '0;
    instruction_i     = '0;
    jump_i            = 1'b0;
    jump_target_i     = '0;
endtask

task automatic idle_cycles(input int n);
    repeat (n) begin
        @(negedge clk);
        idle_inputs();
    end
endtask

task automatic csr_op(input csr_op_e op, input csr_addr_t addr, input xlen_t operand,
                      input logic kill);
    @(negedge clk);
    idle_inputs();
    write_en_i = 1'b1;
    killed_i   = kill;
    op_i       = op;
    addr_i     = addr;
    wdata_i    = operand;
    if (!kill) begin
        mirror_store(addr, ref_merge(op, mirror_value(addr), operand) & ref_mask(addr));
    end
endtask

task automatic read_word(input csr_addr_t addr, input logic en, input logic kill,
                         output xlen_t value);
    @(negedge clk);
    idle_inputs();
    read_en_i = en;
    killed_i  = kill;
    addr_i    = addr;
    #1;                     // Let the read mux settle
    value = rdata_o;
endtask

task automatic read_check(input csr_addr_t addr, input xlen_t expected, input string what);
    xlen_t value;
    read_word(addr, 1'b1, 1'b0, value);
    check_equal(value, expected, what);
endtask

`endif

// File: sim/csr_bank_tb.sv
// Testbench of the machine-mode CSR bank
// Random CSR operations, traps, interrupts and counters checked against a mirror

`timescale 1ns/1ps

module csr_bank_tb;

    import csr_pkg::*;

    logic      clk;
    logic      reset_n;
    logic      read_en_i;
    logic      write_en_i;
    logic      killed_i;
    csr_op_e   op_i;
    csr_addr_t addr_i;
    xlen_t     wdata_i;
    xlen_t     rdata_o;
    logic      raise_exception_i;
    exc_code_t exception_code_i;
    logic      machine_return_i;
    logic      interrupt_ack_i;
    xlen_t     pc_i;
    xlen_t     instruction_i;
    logic      jump_i;
    xlen_t     jump_target_i;
    xlen_t     irq_i;
    logic      interrupt_pending_o;
    priv_e     privilege_o;
    xlen_t     mepc_o;
    xlen_t     mtvec_o;

    xlen_t     mirror [csr_addr_t];    // Trap registers by address
    priv_e     m_priv;
    int        cycle_count = 0;

    csr_bank DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Tests take a few hundred cycles
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == 2000) begin
            $display("Timeout: the tests did not finish within 2000 cycles");
            $display("Something failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    //////////////////////////////
    // Checks and reference model
    //////////////////////////////

    task automatic report_failure(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "Stopped at the first failed check");
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else report_failure(what);
    endtask

    task automatic check_equal(input xlen_t got, input xlen_t expected, input string what);
        assert (got == expected)
            else report_failure($sformatf("%s: got %h, expected %h", what, got, expected));
    endtask

    function automatic xlen_t mirror_value(input csr_addr_t addr);
        return mirror.exists(addr) ? mirror[addr] : '0;
    endfunction

    function automatic void mirror_store(input csr_addr_t addr, input xlen_t value);
        if (mirror.exists(addr)) mirror[addr] = value;    // Counters are not mirrored
    endfunction

    // Status stacking common to exceptions and interrupts
    function automatic void enter_trap();
        xlen_t st;
        st        = mirror[MSTATUS];
        st[7]     = st[3];
        st[3]     = 1'b0;
        st[12:11] = m_priv;
        mirror[MSTATUS] = st;
        m_priv    = PRIV_MACHINE;
    endfunction

    `include "csr_tb_tasks.svh"

    // External, then software, then timer
    function automatic irq_code_t expected_irq_cause(input xlen_t bits);
        if (bits[11]) return 5'd11;
        if (bits[3])  return 5'd3;
        if (bits[7])  return 5'd7;
        return 5'd0;
    endfunction

    task automatic raise_exception(input exc_code_t code, input xlen_t pc, input xlen_t instr);
        @(negedge clk);
        idle_inputs();
        raise_exception_i = 1'b1;
        exception_code_i  = code;
        pc_i              = pc;
        instruction_i     = instr;
        mirror[MCAUSE]    = {27'd0, code};
        mirror[MEPC]      = pc;
        mirror[MTVAL]     = (code == 5'd2) ? instr : pc;   // Illegal instruction
        enter_trap();
    endtask

    task automatic take_interrupt(input xlen_t pc, input xlen_t target, input irq_code_t cause);
        @(negedge clk);
        idle_inputs();
        interrupt_ack_i = 1'b1;
        jump_i          = 1'b1;
        pc_i            = pc;
        jump_target_i   = target;
        mirror[MCAUSE]  = {1'b1, 26'd0, cause};
        mirror[MEPC]    = target;
        enter_trap();
    endtask

    task automatic check_trap_state(input string what);
        read_check(MCAUSE, mirror_value(MCAUSE), {what, " mcause"});
        check_equal(mepc_o, mirror_value(MEPC), {what, " mepc_o"});
        check_true(privilege_o == m_priv, {what, " privilege"});
        read_check(MTVAL, mirror_value(MTVAL), {what, " mtval"});
        read_check(MSTATUS, mirror_value(MSTATUS), {what, " mstatus"});
    endtask

    task automatic random_ops(input csr_addr_t addr, input int count);
        xlen_t   r;
        csr_op_e op;
        repeat (count) begin
            r = lcg_next();
            case (r[1:0])
                2'd0:    op = CSR_SET;
                2'd1:    op = CSR_CLEAR;
                default: op = CSR_WRITE;
            endcase
            csr_op(op, addr, lcg_next(), 1'b0);
            read_check(addr, mirror_value(addr), "random operation readback");
            check_equal(mtvec_o, mirror_value(MTVEC), "mtvec_o output");
            check_equal(mepc_o, mirror_value(MEPC), "mepc_o output");
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        xlen_t first;
        xlen_t second;
        xlen_t r;
        xlen_t target;
        int    kills;

        reset_n = 1'b0;
        irq_i   = '0;
        idle_inputs();
        mirror[MSTATUS]  = '0;
        mirror[MIE]      = '0;
        mirror[MTVEC]    = '0;
        mirror[MSCRATCH] = '0;
        mirror[MEPC]     = '0;
        mirror[MCAUSE]   = '0;
        mirror[MTVAL]    = '0;
        m_priv = PRIV_MACHINE;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        #1;
        check_true(!interrupt_pending_o && privilege_o == PRIV_MACHINE, "reset state");
        check_true(mepc_o == '0 && mtvec_o == '0, "reset mepc_o and mtvec_o");

        random_ops(MSCRATCH, 6);
        random_ops(MTVEC, 6);
        random_ops(MIE, 6);
        random_ops(MEPC, 6);
        random_ops(MSTATUS, 6);

        // Access gating, read-only and unmapped addresses
        csr_op(CSR_WRITE, MSCRATCH, lcg_next(), 1'b1);
        read_check(MSCRATCH, mirror_value(MSCRATCH), "killed write");
        read_word(MSCRATCH, 1'b0, 1'b0, r);
        check_equal(r, '0, "read without enable");
        read_word(MSCRATCH, 1'b1, 1'b1, r);
        check_equal(r, '0, "killed read");
        csr_op(CSR_WRITE, MISA, lcg_next(), 1'b0);
        read_check(MISA, 32'h4010_0100, "misa after write");   // MXL 1, U and I
        read_check(12'h7C0, '0, "unmapped address");

        csr_op(CSR_SET, MSTATUS, 32'h8, 1'b0);
        raise_exception(5'd2, lcg_next(), lcg_next());
        check_trap_state("illegal instruction");
        raise_exception(5'd5, lcg_next(), lcg_next());
        check_trap_state("load fault");

        // MPIE set, MPP user, then mret
        csr_op(CSR_WRITE, MSTATUS, 32'h80, 1'b0);
        @(negedge clk);
        idle_inputs();
        machine_return_i = 1'b1;
        r      = mirror_value(MSTATUS);
        r[3]   = r[7];
        mirror[MSTATUS] = r;
        m_priv = priv_e'(r[12:11]);
        read_check(MSTATUS, mirror_value(MSTATUS), "mret mstatus");
        check_true(privilege_o == PRIV_USER && m_priv == PRIV_USER, "mret privilege");

        // External and timer lines together
        csr_op(CSR_WRITE, MIE, 32'h888, 1'b0);
        @(negedge clk);
        idle_inputs();
        irq_i = 32'h880;
        idle_cycles(1);
        #1;
        check_true(!interrupt_pending_o, "pending one cycle after irq");
        idle_cycles(1);
        #1;
        check_true(interrupt_pending_o, "pending two cycles after irq");
        target = lcg_next();
        take_interrupt(lcg_next(), target, expected_irq_cause(irq_i & mirror_value(MIE)));
        check_trap_state("interrupt");
        check_equal(mepc_o, target, "interrupt mepc_o");
        repeat (5) begin
            idle_cycles(1);
            #1;
            check_true(!interrupt_pending_o, "pending with MIE clear");
        end
        irq_i = '0;

        read_word(MCYCLE, 1'b1, 1'b0, first);
        idle_cycles(23);
        read_word(MCYCLE, 1'b1, 1'b0, second);
        check_equal(second - first, 32'd24, "mcycle over 24 cycles");

        kills = 0;
        read_word(MINSTRET, 1'b1, 1'b0, first);
        repeat (23) begin
            @(negedge clk);
            idle_inputs();
            r = lcg_next();
            killed_i = r[9];
            if (r[9]) kills = kills + 1;
        end
        read_word(MINSTRET, 1'b1, 1'b0, second);
        check_equal(second - first, 32'd24 - kills, "minstret with killed cycles");

        r = lcg_next();
        csr_op(CSR_WRITE, MCYCLEH, r, 1'b0);
        read_check(MCYCLEH, r, "mcycleh write");

        $display("Everything OK");
        $finish;
    end

endmodule

// File: csr_bank.f
+incdir+sim
design/csr_pkg.sv
design/csr_access.sv
design/csr_trap_regs.sv
design/csr_counters.sv
design/csr_irq_ctrl.sv
design/csr_read_mux.sv
design/csr_bank.sv
sim/csr_bank_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the CSR bank testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f csr_bank.f --top-module csr_bank_tb -Mdir obj_dir
./obj_dir/Vcsr_bank_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
